// ==== sim/cake_patterns.txt ====
# KEY name code(hex) count | PIX name x y (decimal) r g b (hex)
# SCORE name p1 p2 (decimal) hex p1_tens p1_ones p2_tens p2_ones (hex, active low a..g)
PIX rst_base 40 55 3FF 105 180
PIX rst_top 38 25 3FF 190 200
PIX rst_white 5 5 3FF 3FF 3FF
SCORE rst_score 0 0 01 01 01 01
PIX p1_body 50 400 3FF 3FF 000
PIX p1_goggle 50 330 000 000 000
PIX p2_body 570 400 209 163 249
PIX pre_move 50 260 3FF 3FF 3FF
KEY p1_up_x8 1D 8
PIX moved_up 50 260 3FF 3FF 000
KEY p1_left_x3 1C 3
PIX clamp_left 5 260 3FF 3FF 000
PIX clamp_edge 75 260 3FF 3FF 3FF
KEY unknown_code 55 1
PIX unknown_same 5 260 3FF 3FF 000
PIX pre_eat_mid 40 40 3FF 2C0 2CB
KEY p1_up_x17 1D 17
PIX eat_overlap 40 55 3FF 3FF 000
PIX eaten_gone 40 40 3FF 3FF 3FF
SCORE p1_one 1 0 01 4F 01 01
KEY p1_right_x31 23 31
KEY p2_left_x17 6B 17
KEY p2_up_x17 75 17
PIX tie_p1 375 135 3FF 3FF 000
SCORE tie_score 2 0 01 12 01 01
KEY p2_right 74 1
PIX pre_p2_eat 458 188 3FF 190 200
PIX p2_eat 445 215 209 163 249
PIX p2_eaten_gone 458 188 3FF 3FF 3FF
SCORE final_score 2 1 01 12 01 4F

// ==== tb.f ====
hdl/video_pkg.sv
hdl/play_pkg.sv
hdl/scan_decode.sv
hdl/player_motion.sv
hdl/cake_field.sv
hdl/pixel_mixer.sv
hdl/score_display.sv
hdl/cake_game_top.sv
sim/tb_cake_game.sv

// ==== Makefile ====
TOP = tb_cake_game

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f tb.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_cake_game.sv ====
`timescale 1ns/1ps

module tb_cake_game;

  import video_pkg::*;
  import play_pkg::*;

  localparam string PATTERN_FILE  = "sim/cake_patterns.txt";
  localparam int    RESET_CYCLES  = 3;
  localparam int    CYCLES_PER_OP = 40;

  logic       CLK;
  logic       arst_n;
  logic [7:0] scan_code;
  logic       scan_ready;
  pixel_pos_t pix_in;
  logic       pix_valid;
  rgb_t       pix_out;
  logic       pix_out_valid;
  score_t     score_p1;
  score_t     score_p2;
  seg_t [0:3] hex;

  string lines[$];
  int    cycle_count = 0;
  int    cycle_limit = 1000;

  cake_game_top DUT (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .scan_code     (scan_code),
    .scan_ready    (scan_ready),
    .pix_in        (pix_in),
    .pix_valid     (pix_valid),
    .pix_out       (pix_out),
    .pix_out_valid (pix_out_valid),
    .score_p1      (score_p1),
    .score_p2      (score_p2),
    .hex           (hex)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // --------------------
  // failure reporting
  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input string expected, input string actual);
    $display("[ERROR] %s: %s expected %s, actual %s", test, what, expected, actual);
    stop_run();
  endtask

  function automatic string rgb_text(input rgb_t c);
    return $sformatf("%03h/%03h/%03h", c.r, c.g, c.b);
  endfunction

  // watchdog
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("cycle limit of %0d reached before the patterns were done", cycle_limit);
      stop_run();
    end
  end

  // --------------------
  // drivers and checks
  task automatic send_key(input logic [7:0] code);
    @(posedge CLK);
    scan_code  <= code;
    scan_ready <= 1'b1;
    @(posedge CLK);
    scan_ready <= 1'b0;
    repeat (2) @(posedge CLK);
  endtask

  // result is due exactly two cycles after the pixel
  task automatic probe_pixel(input string test, input int px, input int py,
                             input rgb_t expected);
    pixel_pos_t pos;
    pos.x = coord_t'(px);
    pos.y = coord_t'(py);
    @(posedge CLK);
    pix_in    <= pos;
    pix_valid <= 1'b1;
    @(posedge CLK);
    pix_valid <= 1'b0;
    @(posedge CLK);
    @(negedge CLK);
    assert (pix_out_valid === 1'b1)
      else begin
        $display("%s: no valid pixel came out two cycles after the input", test);
        stop_run();
      end
    assert (pix_out === expected)
      else report_mismatch(test, "colour", rgb_text(expected), rgb_text(pix_out));
  endtask

  task automatic check_scores(input string test, input int p1, input int p2,
                              input seg_t [0:3] segs);
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    assert (score_p1 === score_t'(p1))
      else report_mismatch(test, "score_p1", $sformatf("%0d", p1),
                           $sformatf("%0d", score_p1));
    assert (score_p2 === score_t'(p2))
      else report_mismatch(test, "score_p2", $sformatf("%0d", p2),
                           $sformatf("%0d", score_p2));
    for (int i = 0; i < 4; i++) begin
      assert (hex[i] === segs[i])
        else report_mismatch(test, $sformatf("hex[%0d]", i), $sformatf("%02h", segs[i]),
                             $sformatf("%02h", hex[i]));
    end
  endtask

  // --------------------
  // pattern file
  task automatic load_patterns();
    int    fd;
    int    rc;
    int    ops;
    int    code;
    int    count;
    string line;
    string op;
    string test;
    ops = 0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("could not open the pattern file %s", PATTERN_FILE);
      stop_run();
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc > 0 && $sscanf(line, "%s %s", op, test) == 2 && op.substr(0, 0) != "#") begin
        lines.push_back(line);
        if (op == "KEY" && $sscanf(line, "%s %s %h %d", op, test, code, count) == 4) begin
          ops += count;
        end else begin
          ops += 1;
        end
      end
    end
    $fclose(fd);
    cycle_limit = CYCLES_PER_OP * ops + RESET_CYCLES;
  endtask

  task automatic run_line(input string line);
    string      op;
    string      test;
    int         n;
    int         num [6];
    rgb_t       color;
    seg_t [0:3] segs;
    n = $sscanf(line, "%s %s", op, test);
    case (op)
      "KEY": begin
        // code, repeat count
        n = $sscanf(line, "%s %s %h %d", op, test, num[0], num[1]);
        assert (n == 4) else begin
          $display("KEY line has missing fields: %s", line);
          stop_run();
        end
        repeat (num[1]) send_key(num[0][7:0]);
      end
      "PIX": begin
        n = $sscanf(line, "%s %s %d %d %h %h %h", op, test,
                    num[0], num[1], num[2], num[3], num[4]);
        assert (n == 7) else begin
          $display("PIX line has missing fields: %s", line);
          stop_run();
        end
        color.r = channel_t'(num[2]);
        color.g = channel_t'(num[3]);
        color.b = channel_t'(num[4]);
        probe_pixel(test, num[0], num[1], color);
      end
      "SCORE": begin
        n = $sscanf(line, "%s %s %d %d %h %h %h %h", op, test,
                    num[0], num[1], num[2], num[3], num[4], num[5]);
        assert (n == 8) else begin
          $display("SCORE line has missing fields: %s", line);
          stop_run();
        end
        for (int i = 0; i < 4; i++) begin
          segs[i] = seg_t'(num[i+2]);
        end
        check_scores(test, num[0], num[1], segs);
      end
      default: begin
        $display("unknown operation in pattern line: %s", line);
        stop_run();
      end
    endcase
  endtask

  // --------------------
  // main sequence
  initial begin
    arst_n     = 1'b0;
    scan_code  = '0;
    scan_ready = 1'b0;
    pix_in     = '0;
    pix_valid  = 1'b0;
    load_patterns();
    repeat (RESET_CYCLES) @(posedge CLK);
    arst_n <= 1'b1;
    foreach (lines[i]) begin
      run_line(lines[i]);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== hdl/cake_game_top.sv ====
`timescale 1ns/1ps

module cake_game_top (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic [7:0]            scan_code,
  input  logic                  scan_ready,
  input  video_pkg::pixel_pos_t pix_in,
  input  logic                  pix_valid,
  output video_pkg::rgb_t       pix_out,
  output logic                  pix_out_valid,
  output play_pkg::score_t      score_p1,
  output play_pkg::score_t      score_p2,
  output video_pkg::seg_t [0:3] hex
);

  import play_pkg::*;

  move_cmd_t   move_cmd;
  sprite_hit_t sprite_hit;
  logic        sprite_valid;
  cake_hit_t   cake_hit;

  // --------------------
  // decode
  scan_decode u_scan_decode (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .scan_code  (scan_code),
    .scan_ready (scan_ready),
    .move_cmd   (move_cmd)
  );

  // --------------------
  // execute
  player_motion u_player_motion (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .move_cmd     (move_cmd),
    .pix_in       (pix_in),
    .pix_valid    (pix_valid),
    .sprite_hit   (sprite_hit),
    .sprite_valid (sprite_valid)
  );

  cake_field u_cake_field (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .pix_in       (pix_in),
    .pix_valid    (pix_valid),
    .sprite_hit   (sprite_hit),
    .sprite_valid (sprite_valid),
    .cake_hit     (cake_hit),
    .score_p1     (score_p1),
    .score_p2     (score_p2)
  );

  // --------------------
  // result
  pixel_mixer u_pixel_mixer (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .sprite_hit    (sprite_hit),
    .sprite_valid  (sprite_valid),
    .cake_hit      (cake_hit),
    .pix_out       (pix_out),
    .pix_out_valid (pix_out_valid)
  );

  score_display u_score_display (
    .score_p1 (score_p1),
    .score_p2 (score_p2),
    .hex      (hex)
  );

endmodule

// ==== hdl/score_display.sv ====
`timescale 1ns/1ps

module score_display (
  input  play_pkg::score_t       score_p1,
  input  play_pkg::score_t       score_p2,
  output video_pkg::seg_t [0:3]  hex
);

  import video_pkg::*;
  import play_pkg::*;

  function automatic score_t tens_of(score_t s);
    return (s >= 4'd10) ? 4'd1 : 4'd0;
  endfunction

  function automatic score_t ones_of(score_t s);
    return (s >= 4'd10) ? s - 4'd10 : s;
  endfunction

  // segments a..g, low lights the segment
  function automatic seg_t digit_seg(score_t d);
    case (d)
      4'd0:    return 7'b0000001;
      4'd1:    return 7'b1001111;
      4'd2:    return 7'b0010010;
      4'd3:    return 7'b0000110;
      4'd4:    return 7'b1001100;
      4'd5:    return 7'b0100100;
      4'd6:    return 7'b0100000;
      4'd7:    return 7'b0001111;
      4'd8:    return 7'b0000000;
      4'd9:    return 7'b0000100;
      default: return 7'b1111111;
    endcase
  endfunction

  // p1 tens, p1 ones, p2 tens, p2 ones
  always_comb begin
    hex[0] = digit_seg(tens_of(score_p1));
    hex[1] = digit_seg(ones_of(score_p1));
    hex[2] = digit_seg(tens_of(score_p2));
    hex[3] = digit_seg(ones_of(score_p2));
  end

endmodule

// ==== hdl/pixel_mixer.sv ====
`timescale 1ns/1ps

module pixel_mixer (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  play_pkg::sprite_hit_t sprite_hit,
  input  logic                  sprite_valid,
  input  play_pkg::cake_hit_t   cake_hit,
  output video_pkg::rgb_t       pix_out,
  output logic                  pix_out_valid
);

  import video_pkg::*;
  import play_pkg::*;

  rgb_t color;

  // --------------------
  // layer priority
  // player one over player two over cakes over background
  always_comb begin
    if (sprite_hit.hit[PLAYER_ONE]) begin
      color = sprite_hit.goggle[PLAYER_ONE] ? COLOR_BLACK : COLOR_P1_BODY;
    end else if (sprite_hit.hit[PLAYER_TWO]) begin
      color = sprite_hit.goggle[PLAYER_TWO] ? COLOR_BLACK : COLOR_P2_BODY;
    end else if (cake_hit.hit) begin
      case (cake_hit.tier)
        TIER_TOP: color = COLOR_TIER_TOP;
        TIER_MID: color = COLOR_TIER_MID;
        default:  color = COLOR_TIER_BASE;
      endcase
    end else begin
      color = COLOR_WHITE;
    end
  end

  // --------------------
  // output stage
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pix_out_valid <= 1'b0;
    end else begin
      pix_out_valid <= sprite_valid;
    end
  end

  always_ff @(posedge CLK) begin
    pix_out <= color;
  end

endmodule

// ==== hdl/cake_field.sv ====
`timescale 1ns/1ps

module cake_field (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  video_pkg::pixel_pos_t pix_in,
  input  logic                  pix_valid,
  input  play_pkg::sprite_hit_t sprite_hit,
  input  logic                  sprite_valid,
  output play_pkg::cake_hit_t   cake_hit,
  output play_pkg::score_t      score_p1,
  output play_pkg::score_t      score_p2
);

  import video_pkg::*;
  import play_pkg::*;

  cake_mask_t [NUM_PLAYERS-1:0] eaten;
  cake_mask_t                   eaten_any;
  cake_hit_t                    hit_next;
  logic                         eat;
  player_t                      owner;

  assign eaten_any = eaten[PLAYER_ONE] | eaten[PLAYER_TWO];

  // --------------------
  // cake lookup
  // walk downwards so the lowest index wins
  always_comb begin
    coord_t cx;
    coord_t cy;
    hit_next = '0;
    for (int i = NUM_CAKES - 1; i >= 0; i--) begin
      cx = CAKE_POS[i].x;
      cy = CAKE_POS[i].y;
      if (!eaten_any[i] && inside_box(pix_in, cx, cy, CAKE_W, CAKE_H)) begin
        hit_next.idx = cake_idx_t'(i);
        hit_next.hit = pix_valid;
        hit_next.tier = TIER_TOP;
        if (inside_box(pix_in, cx + TOP_X0, cy, TOP_X1 - TOP_X0, TOP_Y1)) begin
          hit_next.tier = TIER_TOP;
        end else if (inside_box(pix_in, cx + MID_X0, cy + MID_Y0,
                                MID_X1 - MID_X0, MID_Y1 - MID_Y0)) begin
          hit_next.tier = TIER_MID;
        end else if (inside_box(pix_in, cx, cy + BASE_Y0, CAKE_W, CAKE_H - BASE_Y0)) begin
          hit_next.tier = TIER_BASE;
        end else begin
          // corners beside the upper tiers are background
          hit_next.hit = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cake_hit <= '0;
    end else begin
      cake_hit <= hit_next;
    end
  end

  // --------------------
  // eating and scores
  // re-check the mask, an earlier pixel may have just taken this cake
  assign eat = cake_hit.hit && sprite_valid && !eaten_any[cake_hit.idx] &&
               (|sprite_hit.hit);
  assign owner = sprite_hit.hit[PLAYER_ONE] ? PLAYER_ONE : PLAYER_TWO;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      eaten <= '0;
    end else if (eat) begin
      eaten[owner][cake_hit.idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      score_p1 <= '0;
      score_p2 <= '0;
    end else begin
      score_p1 <= score_t'($countones(eaten[PLAYER_ONE]));
      score_p2 <= score_t'($countones(eaten[PLAYER_TWO]));
    end
  end

  a_masks_disjoint: assert property (
    @(posedge CLK) disable iff (!arst_n)
    (eaten[PLAYER_ONE] & eaten[PLAYER_TWO]) == '0
  );

  // a cake once eaten keeps its owner
  a_eaten_sticky: assert property (
    @(posedge CLK) disable iff (!arst_n)
    ($past(eaten) & ~eaten) == '0
  );

endmodule

// ==== hdl/player_motion.sv ====
`timescale 1ns/1ps

module player_motion (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  play_pkg::move_cmd_t   move_cmd,
  input  video_pkg::pixel_pos_t pix_in,
  input  logic                  pix_valid,
  output play_pkg::sprite_hit_t sprite_hit,
  output logic                  sprite_valid
);

  import video_pkg::*;
  import play_pkg::*;

  pixel_pos_t [NUM_PLAYERS-1:0] origin;
  pixel_pos_t [NUM_PLAYERS-1:0] origin_next;
  pixel_pos_t                   cur;
  sprite_hit_t                  hit_next;

  function automatic coord_t dec_clamp(coord_t v);
    return (v < MOVE_STEP) ? '0 : v - MOVE_STEP;
  endfunction

  function automatic coord_t inc_clamp(coord_t v, coord_t lim);
    return (v + MOVE_STEP > lim) ? lim : v + MOVE_STEP;
  endfunction

  // --------------------
  // movement
  assign cur = origin[move_cmd.player];

  always_comb begin
    origin_next = origin;
    if (move_cmd.valid) begin
      case (move_cmd.dir)
        DIR_UP:    origin_next[move_cmd.player].y = dec_clamp(cur.y);
        DIR_DOWN:  origin_next[move_cmd.player].y = inc_clamp(cur.y, SPRITE_Y_MAX);
        DIR_LEFT:  origin_next[move_cmd.player].x = dec_clamp(cur.x);
        DIR_RIGHT: origin_next[move_cmd.player].x = inc_clamp(cur.x, SPRITE_X_MAX);
      endcase
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      origin[PLAYER_ONE] <= P1_START;
      origin[PLAYER_TWO] <= P2_START;
    end else begin
      origin <= origin_next;
    end
  end

  // --------------------
  // per pixel classification
  always_comb begin
    for (int p = 0; p < NUM_PLAYERS; p++) begin
      hit_next.hit[p] = inside_box(pix_in, origin[p].x, origin[p].y, SPRITE_W, SPRITE_H);
      // goggle band spans the full sprite width
      hit_next.goggle[p] = hit_next.hit[p] &&
        inside_box(pix_in, origin[p].x, origin[p].y + GOGGLE_Y0,
                   SPRITE_W, GOGGLE_Y1 - GOGGLE_Y0);
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sprite_valid <= 1'b0;
    end else begin
      sprite_valid <= pix_valid;
    end
  end

  always_ff @(posedge CLK) begin
    sprite_hit <= hit_next;
  end

  a_origin_range: assert property (
    @(posedge CLK) disable iff (!arst_n)
    (origin[0].x <= SPRITE_X_MAX) && (origin[0].y <= SPRITE_Y_MAX) &&
    (origin[1].x <= SPRITE_X_MAX) && (origin[1].y <= SPRITE_Y_MAX)
  );

endmodule

// ==== hdl/scan_decode.sv ====
`timescale 1ns/1ps

module scan_decode (
  input  logic                CLK,
  input  logic                arst_n,
  input  logic [7:0]          scan_code,
  input  logic                scan_ready,
  output play_pkg::move_cmd_t move_cmd
);

  import play_pkg::*;

  move_cmd_t cmd_next;

  // table lookup, anything else stays invalid
  always_comb begin
    cmd_next = '0;
    if (scan_ready) begin
      case (scan_code)
        KEY_P1_UP:    cmd_next = '{valid: 1'b1, player: PLAYER_ONE, dir: DIR_UP};
        KEY_P1_DOWN:  cmd_next = '{valid: 1'b1, player: PLAYER_ONE, dir: DIR_DOWN};
        KEY_P1_LEFT:  cmd_next = '{valid: 1'b1, player: PLAYER_ONE, dir: DIR_LEFT};
        KEY_P1_RIGHT: cmd_next = '{valid: 1'b1, player: PLAYER_ONE, dir: DIR_RIGHT};
        KEY_P2_UP:    cmd_next = '{valid: 1'b1, player: PLAYER_TWO, dir: DIR_UP};
        KEY_P2_DOWN:  cmd_next = '{valid: 1'b1, player: PLAYER_TWO, dir: DIR_DOWN};
        KEY_P2_LEFT:  cmd_next = '{valid: 1'b1, player: PLAYER_TWO, dir: DIR_LEFT};
        KEY_P2_RIGHT: cmd_next = '{valid: 1'b1, player: PLAYER_TWO, dir: DIR_RIGHT};
        default:      cmd_next = '0;
      endcase
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      move_cmd <= '0;
    end else begin
      move_cmd <= cmd_next;
    end
  end

  // one command per strobe, never spontaneous
  a_cmd_after_ready: assert property (
    @(posedge CLK) disable iff (!arst_n)
    move_cmd.valid |-> $past(scan_ready)
  );

endmodule

// ==== hdl/play_pkg.sv ====
package play_pkg;

  import video_pkg::*;

  // --------------------
  // players and cakes
  localparam int NUM_PLAYERS = 2;
  typedef logic [$clog2(NUM_PLAYERS)-1:0] player_t;
  localparam player_t PLAYER_ONE = 1'b0;
  localparam player_t PLAYER_TWO = 1'b1;

  localparam int NUM_CAKES = 12;
  typedef logic [3:0] cake_idx_t;
  typedef logic [NUM_CAKES-1:0] cake_mask_t;
  typedef logic [3:0] score_t;

  // --------------------
  // sprite geometry
  localparam coord_t SPRITE_W     = 10'd70;
  localparam coord_t SPRITE_H     = 10'd133;
  localparam coord_t GOGGLE_Y0    = 10'd21;
  localparam coord_t GOGGLE_Y1    = 10'd35;
  localparam coord_t MOVE_STEP    = 10'd10;
  localparam coord_t SPRITE_X_MAX = SCREEN_W - SPRITE_W;
  localparam coord_t SPRITE_Y_MAX = SCREEN_H - SPRITE_H;
  localparam pixel_pos_t P1_START = '{x: 10'd20, y: 10'd300};
  localparam pixel_pos_t P2_START = '{x: 10'd540, y: 10'd300};

  // --------------------
  // cake geometry, offsets from the cake origin
  localparam coord_t CAKE_W  = 10'd42;
  localparam coord_t CAKE_H  = 10'd44;
  localparam coord_t TOP_X0  = 10'd14;
  localparam coord_t TOP_X1  = 10'd28;
  localparam coord_t TOP_Y1  = 10'd14;
  localparam coord_t MID_X0  = 10'd8;
  localparam coord_t MID_X1  = 10'd36;
  localparam coord_t MID_Y0  = 10'd14;
  localparam coord_t MID_Y1  = 10'd28;
  localparam coord_t BASE_Y0 = 10'd28;

  localparam pixel_pos_t CAKE_POS [NUM_CAKES] = '{
    '{x: 10'd20,  y: 10'd20},  '{x: 10'd160, y: 10'd20},  '{x: 10'd300, y: 10'd20},
    '{x: 10'd440, y: 10'd20},  '{x: 10'd580, y: 10'd20},
    '{x: 10'd90,  y: 10'd100}, '{x: 10'd230, y: 10'd100}, '{x: 10'd370, y: 10'd100},
    '{x: 10'd510, y: 10'd100},
    '{x: 10'd160, y: 10'd180}, '{x: 10'd300, y: 10'd180}, '{x: 10'd440, y: 10'd180}
  };

  typedef enum logic [1:0] {DIR_UP, DIR_DOWN, DIR_LEFT, DIR_RIGHT} dir_t;

  // keyboard scan codes
  localparam logic [7:0] KEY_P1_UP    = 8'h1D;
  localparam logic [7:0] KEY_P1_DOWN  = 8'h1B;
  localparam logic [7:0] KEY_P1_LEFT  = 8'h1C;
  localparam logic [7:0] KEY_P1_RIGHT = 8'h23;
  localparam logic [7:0] KEY_P2_UP    = 8'h75;
  localparam logic [7:0] KEY_P2_DOWN  = 8'h72;
  localparam logic [7:0] KEY_P2_LEFT  = 8'h6B;
  localparam logic [7:0] KEY_P2_RIGHT = 8'h74;

  typedef struct packed {
    logic    valid;
    player_t player;
    dir_t    dir;
  } move_cmd_t;

  typedef struct packed {
    logic [NUM_PLAYERS-1:0] hit;
    logic [NUM_PLAYERS-1:0] goggle;
  } sprite_hit_t;

  typedef enum logic [1:0] {TIER_TOP, TIER_MID, TIER_BASE} tier_t;

  typedef struct packed {
    logic      hit;
    cake_idx_t idx;
    tier_t     tier;
  } cake_hit_t;

endpackage

// ==== hdl/video_pkg.sv ====
package video_pkg;

  // --------------------
  // pixel and colour types
  typedef logic [9:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } pixel_pos_t;

  typedef logic [9:0] channel_t;

  typedef struct packed {
    channel_t r;
    channel_t g;
    channel_t b;
  } rgb_t;

  // active low, index 0 is segment a
  typedef logic [0:6] seg_t;

  localparam coord_t SCREEN_W = 10'd640;
  localparam coord_t SCREEN_H = 10'd480;

  // --------------------
  // palette
  localparam rgb_t COLOR_WHITE     = '{r: 10'h3FF, g: 10'h3FF, b: 10'h3FF};
  localparam rgb_t COLOR_BLACK     = '{r: 10'h000, g: 10'h000, b: 10'h000};
  localparam rgb_t COLOR_P1_BODY   = '{r: 10'h3FF, g: 10'h3FF, b: 10'h000};
  localparam rgb_t COLOR_P2_BODY   = '{r: 10'h209, g: 10'h163, b: 10'h249};
  localparam rgb_t COLOR_TIER_TOP  = '{r: 10'h3FF, g: 10'h190, b: 10'h200};
  localparam rgb_t COLOR_TIER_MID  = '{r: 10'h3FF, g: 10'h2C0, b: 10'h2CB};
  localparam rgb_t COLOR_TIER_BASE = '{r: 10'h3FF, g: 10'h105, b: 10'h180};

  // strict open box, edges themselves are outside
  function automatic logic inside_box(pixel_pos_t p, coord_t x0, coord_t y0,
                                      coord_t w, coord_t h);
    return (p.x > x0) && (p.x < x0 + w) && (p.y > y0) && (p.y < y0 + h);
  endfunction

endpackage
